// File: ex_macros.svh
/* Execute stage build constants
   Data width, register address width and high-multiply latency */

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

//////////////////////////////////////////////////
// Datapath sizes
//////////////////////////////////////////////////

// Integer register width
`define EX_XLEN 32

// Register file address width, 32 registers
`define EX_RADDR_W 5

//////////////////////////////////////////////////
// Multiplier timing
//////////////////////////////////////////////////

// Cycles that MULH and MULHU occupy EX
`define EX_MULH_CYCLES 2

`endif

// File: ex_pkg.sv
/* Shared types for the execute stage
   Opcode enums and the request, forwarding and write-back structs */

`include "ex_macros.svh"
`default_nettype none

package ex_pkg;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  // ALU operations, full 4-bit space in use
  typedef enum logic [3:0] {
    ADD,   // a + b
    SUB,   // a - b
    AND,
    OR,
    XOR,
    SLL,   // Shift left logical
    SRL,   // Shift right logical
    SRA,   // Shift right arithmetic
    SLT,   // Set less than, signed
    SLTU,  // Set less than, unsigned
    EQ,    // Branch compares from here on
    NE,
    LT,
    GE,
    LTU,
    GEU
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [1:0] {
    MUL,    // Low word of a*b
    MULH,   // High word, signed x signed
    MULHU,  // High word, unsigned x unsigned
    MAC     // Low word of a*b + c
  } mult_op_e;

  //////////////////////////////////////////////////
  // Pipeline structs
  //////////////////////////////////////////////////

  // Decoded instruction as held in ID/EX
  typedef struct packed {
    alu_op_e                 alu_op;
    mult_op_e                mult_op;
    logic                    mult_en;     // Result from multiplier
    logic [`EX_XLEN-1:0]     operand_a;
    logic [`EX_XLEN-1:0]     operand_b;
    logic [`EX_XLEN-1:0]     operand_c;   // Jump target or MAC addend
    logic                    alu_we;      // Write through ALU port
    logic [`EX_RADDR_W-1:0]  alu_waddr;
    logic                    lsu_we;      // Load result written in WB
    logic [`EX_RADDR_W-1:0]  lsu_waddr;
    logic                    branch;
    logic                    csr_access;  // Result from CSR file
    logic [`EX_XLEN-1:0]     csr_rdata;
  } ex_req_t;

  // Forwarding write, ALU port of the register file
  typedef struct packed {
    logic                    we;
    logic [`EX_RADDR_W-1:0]  waddr;
    logic [`EX_XLEN-1:0]     wdata;
  } ex_fwd_t;

  // Load write held for WB
  typedef struct packed {
    logic                    we;
    logic [`EX_RADDR_W-1:0]  waddr;
  } ex_wb_t;

endpackage

`default_nettype wire

// File: ex_alu.sv
/* Integer ALU, purely combinational
   Shared adder/subtractor, logic ops, barrel shifter and compares */

`timescale 1ns/100ps
`include "ex_macros.svh"
`default_nettype none

module ex_alu
  import ex_pkg::*;
(
  input  alu_op_e              operator_i,
  input  logic [`EX_XLEN-1:0]  operand_a_i,
  input  logic [`EX_XLEN-1:0]  operand_b_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 cmp_result_o
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic                    is_sub;        // Everything but ADD subtracts
  logic [`EX_XLEN-1:0]     adder_b;
  logic [`EX_XLEN:0]       adder_result;  // Carry out in msb
  logic                    is_eq;
  logic                    is_lt;         // Signed less than
  logic                    is_ltu;        // Unsigned less than

  logic                    shift_left;
  logic                    shift_fill;    // Sign bit for SRA
  logic [`EX_XLEN-1:0]     shift_in;
  logic [2*`EX_XLEN-1:0]   shift_ext;
  logic [`EX_XLEN-1:0]     shift_right;
  logic [`EX_XLEN-1:0]     shift_result;

  //////////////////////////////////////////////////
  // Adder and compares
  //////////////////////////////////////////////////

  assign is_sub  = (operator_i != ADD);
  assign adder_b = is_sub ? ~operand_b_i : operand_b_i;  // Two's complement with carry in

  assign adder_result = {1'b0, operand_a_i} + {1'b0, adder_b}
                      + {{`EX_XLEN{1'b0}}, is_sub};

  assign is_eq  = (adder_result[`EX_XLEN-1:0] == '0);
  assign is_ltu = ~adder_result[`EX_XLEN];  // No carry means borrow

  // Differing signs decide directly, else the difference sign
  assign is_lt = (operand_a_i[`EX_XLEN-1] != operand_b_i[`EX_XLEN-1]) ?
                 operand_a_i[`EX_XLEN-1] : adder_result[`EX_XLEN-1];

  always_comb
  begin
    case (operator_i)
      EQ:          cmp_result_o = is_eq;
      NE:          cmp_result_o = ~is_eq;
      LT, SLT:     cmp_result_o = is_lt;
      GE:          cmp_result_o = ~is_lt;
      LTU, SLTU:   cmp_result_o = is_ltu;
      GEU:         cmp_result_o = ~is_ltu;
      default:     cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  // Left shifts reuse the right shifter on bit-reversed data
  assign shift_left = (operator_i == SLL);
  assign shift_fill = (operator_i == SRA) & operand_a_i[`EX_XLEN-1];

  always_comb
  begin
    for (int i = 0; i < `EX_XLEN; i++)
    begin
      shift_in[i] = shift_left ? operand_a_i[`EX_XLEN-1-i] : operand_a_i[i];
    end
    shift_ext   = {{`EX_XLEN{shift_fill}}, shift_in} >> operand_b_i[SHAMT_W-1:0];
    shift_right = shift_ext[`EX_XLEN-1:0];
    for (int i = 0; i < `EX_XLEN; i++)
    begin
      shift_result[i] = shift_left ? shift_right[`EX_XLEN-1-i] : shift_right[i];
    end
  end

  // Result select
  always_comb
  begin
    case (operator_i)
      ADD, SUB:   result_o = adder_result[`EX_XLEN-1:0];
      AND:        result_o = operand_a_i & operand_b_i;
      OR:         result_o = operand_a_i | operand_b_i;
      XOR:        result_o = operand_a_i ^ operand_b_i;
      SLL, SRL,
      SRA:        result_o = shift_result;
      default:    result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};  // Compares, flag only
    endcase
  end

endmodule

`default_nettype wire

// File: ex_mult.sv
/* Integer multiplier for the execute stage
   Low word in one cycle, upper half registered and given on the second */

`timescale 1ns/100ps
`include "ex_macros.svh"
`default_nettype none

module ex_mult
  import ex_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable_i,      // Valid multiply in EX
  input  mult_op_e             operator_i,
  input  logic [`EX_XLEN-1:0]  op_a_i,
  input  logic [`EX_XLEN-1:0]  op_b_i,
  input  logic [`EX_XLEN-1:0]  op_c_i,        // MAC addend
  input  logic                 ex_ready_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 multicycle_o,  // First cycle of a high multiply
  output logic                 ready_o
);

  typedef enum logic {IDLE, HIGH} mult_state_e;

  mult_state_e                 state_q, state_d;
  logic                        is_high_op;
  logic                        ext_sign;      // Sign extend both operands
  logic signed [`EX_XLEN:0]    ext_a, ext_b;
  logic signed [2*`EX_XLEN+1:0] product;      // 33x33 covers both signs
  logic [`EX_XLEN-1:0]         low_result;
  logic [`EX_XLEN-1:0]         prod_hi_q;

  //////////////////////////////////////////////////
  // Single product
  //////////////////////////////////////////////////

  assign is_high_op = (operator_i == MULH) || (operator_i == MULHU);
  assign ext_sign   = (operator_i == MULH);

  assign ext_a = {ext_sign & op_a_i[`EX_XLEN-1], op_a_i};
  assign ext_b = {ext_sign & op_b_i[`EX_XLEN-1], op_b_i};

  assign product = ext_a * ext_b;

  // Low word is sign independent
  assign low_result = product[`EX_XLEN-1:0]
                    + ((operator_i == MAC) ? op_c_i : '0);

  //////////////////////////////////////////////////
  // High-half FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    case (state_q)
      IDLE:
      begin
        if (enable_i && is_high_op)
        begin
          ready_o      = 1'b0;  // Hold EX one cycle
          multicycle_o = 1'b1;
          state_d      = HIGH;
        end
      end
      HIGH:
      begin
        if (ex_ready_i)
        begin
          state_d = IDLE;  // Instruction leaves EX
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // Upper word captured in the first cycle
  always_ff @(posedge clk)
  begin
    if (multicycle_o)
      prod_hi_q <= product[2*`EX_XLEN-1:`EX_XLEN];
  end

  assign result_o = (state_q == HIGH) ? prod_hi_q : low_result;

endmodule

`default_nettype wire

// File: ex_stage.sv
/* Execute stage with ALU and multiplier
   Result select, forwarding, branch outputs, stall control, EX/WB register */

`timescale 1ns/100ps
`include "ex_macros.svh"
`default_nettype none

module ex_stage
  import ex_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  ex_req_t              id_ex_i,
  input  logic                 id_ex_valid_i,      // EX holds an instruction
  input  logic                 lsu_ready_i,        // LSU done with its EX part
  input  logic                 wb_ready_i,
  output ex_fwd_t              fwd_o,              // ALU port write and forwarding
  output logic                 branch_decision_o,
  output logic [`EX_XLEN-1:0]  jump_target_o,
  output ex_wb_t               wb_o,               // Load write for WB
  output logic                 mult_multicycle_o,
  output logic                 ex_ready_o,         // EX takes new data
  output logic                 ex_valid_o          // EX hands data to WB
);

  logic [`EX_XLEN-1:0]  alu_result;
  logic                 alu_cmp_result;
  logic [`EX_XLEN-1:0]  mult_result;
  logic                 mult_ready;
  logic                 mult_enable;
  logic                 branch_in_ex;
  logic                 we_conflict;   // Both write ports busy
  logic                 wb_load_we;

  //////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////

  ex_alu alu_i (
    .operator_i   (id_ex_i.alu_op),
    .operand_a_i  (id_ex_i.operand_a),
    .operand_b_i  (id_ex_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  assign mult_enable = id_ex_i.mult_en & id_ex_valid_i;  // Ignore stale contents

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_enable),
    .operator_i   (id_ex_i.mult_op),
    .op_a_i       (id_ex_i.operand_a),
    .op_b_i       (id_ex_i.operand_b),
    .op_c_i       (id_ex_i.operand_c),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  //////////////////////////////////////////////////
  // Result select and forwarding
  //////////////////////////////////////////////////

  always_comb
  begin
    if (id_ex_i.mult_en)
      fwd_o.wdata = mult_result;
    else if (id_ex_i.csr_access)
      fwd_o.wdata = id_ex_i.csr_rdata;
    else
      fwd_o.wdata = alu_result;
  end

  assign fwd_o.we    = id_ex_i.alu_we & id_ex_valid_i;
  assign fwd_o.waddr = id_ex_i.alu_waddr;

  // Branch outcome straight to fetch
  assign branch_in_ex      = id_ex_i.branch & id_ex_valid_i;
  assign branch_decision_o = alu_cmp_result & branch_in_ex;
  assign jump_target_o     = id_ex_i.operand_c;

  //////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////

  // Two register file ports so a load in WB blocks an ALU write
  assign we_conflict = wb_o.we & fwd_o.we;

  // ALU is single cycle and never holds EX
  assign ex_valid_o = mult_ready & lsu_ready_i & wb_ready_i;
  // Branches finish without WB
  assign ex_ready_o = (ex_valid_o & ~we_conflict) | branch_in_ex;

  // EX/WB register
  assign wb_load_we = id_ex_i.lsu_we & id_ex_valid_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_o <= '0;
    end
    else if (ex_valid_o)
    begin
      wb_o.we <= wb_load_we;
      if (wb_load_we)
        wb_o.waddr <= id_ex_i.lsu_waddr;
    end
    else if (wb_ready_i)
    begin
      wb_o.we <= 1'b0;  // WB drained with nothing new
    end
  end

endmodule

`default_nettype wire

// File: ex_issue.sv
/* ID/EX pipeline register
   Takes decoded requests and holds them while EX stalls */

`timescale 1ns/100ps
`include "ex_macros.svh"
`default_nettype none

module ex_issue
  import ex_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  ex_req_t  req_i,          // From decode
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  logic     ex_ready_i,     // EX releases its instruction
  output ex_req_t  id_ex_o,
  output logic     id_ex_valid_o
);

  logic accept;  // Request taken this cycle

  // Room when empty or when the current one leaves
  assign req_ready_o = ~id_ex_valid_o | ex_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  //////////////////////////////////////////////////
  // Occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_ex_valid_o <= 1'b0;
    end
    else if (accept)
    begin
      id_ex_valid_o <= 1'b1;
    end
    else if (ex_ready_i)
    begin
      id_ex_valid_o <= 1'b0;  // Left EX, bubble follows
    end
  end

  // Instruction fields, held under stall
  always_ff @(posedge clk)
  begin
    if (accept)
      id_ex_o <= req_i;
  end

endmodule

`default_nettype wire

// File: ex_top.sv
/* Execute stage top level
   ID/EX register feeding the execute stage */

`timescale 1ns/100ps
`include "ex_macros.svh"
`default_nettype none

module ex_top
  import ex_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  ex_req_t              req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic                 lsu_ready_i,
  input  logic                 wb_ready_i,
  output ex_fwd_t              fwd_o,
  output logic                 branch_decision_o,
  output logic [`EX_XLEN-1:0]  jump_target_o,
  output ex_wb_t               wb_o,
  output logic                 mult_multicycle_o,
  output logic                 ex_ready_o,
  output logic                 ex_valid_o
);

  ex_req_t  id_ex;        // Held instruction
  logic     id_ex_valid;

  ex_issue issue_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .ex_ready_i    (ex_ready_o),  // Stall loops back
    .id_ex_o       (id_ex),
    .id_ex_valid_o (id_ex_valid)
  );

  ex_stage stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_i           (id_ex),
    .id_ex_valid_i     (id_ex_valid),
    .lsu_ready_i       (lsu_ready_i),
    .wb_ready_i        (wb_ready_i),
    .fwd_o             (fwd_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o),
    .wb_o              (wb_o),
    .mult_multicycle_o (mult_multicycle_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

endmodule

`default_nettype wire

// File: ex_top_sva.sv
/* Assertions on the execute stage top level
   Stall, high multiply and reset checks, bound to ex_top */

`timescale 1ns/100ps
`include "ex_macros.svh"
`default_nettype none

module ex_top_sva
  import ex_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_ready_i,
  input  logic     lsu_ready_i,
  input  logic     wb_ready_i,
  input  ex_fwd_t  fwd_i,
  input  ex_wb_t   wb_i,
  input  logic     mult_multicycle_i,
  input  logic     ex_ready_i,
  input  logic     ex_valid_i
);

  logic outside_stall;  // EX held by LSU, WB or the write port

  assign outside_stall = ~lsu_ready_i | ~wb_ready_i | (fwd_i.we & wb_i.we);

  //////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////

  // WB takes whatever EX hands over
  valid_needs_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> wb_ready_i)
    else $error("ex_valid_o high while wb_ready_i low");

  // Upper half done by its last cycle unless held from outside
  mulh_done: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_i |-> ##(`EX_MULH_CYCLES-1) (ex_ready_i | outside_stall))
    else $error("high multiply still in EX after its second cycle");

  ready_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> req_ready_i)
    else $error("req_ready_o low in the first cycle after reset");

endmodule

bind ex_top ex_top_sva sva_i (
  .clk               (clk),
  .rst_n             (rst_n),
  .req_ready_i       (req_ready_o),
  .lsu_ready_i       (lsu_ready_i),
  .wb_ready_i        (wb_ready_i),
  .fwd_i             (fwd_o),
  .wb_i              (wb_o),
  .mult_multicycle_i (mult_multicycle_o),
  .ex_ready_i        (ex_ready_o),
  .ex_valid_i        (ex_valid_o)
);

`default_nettype wire

// File: tb_ex_top.sv
/* Testbench for the execute stage top level
   Random requests, reference model, commit checker and watchdog */

`timescale 1ns/100ps
`include "ex_macros.svh"
`default_nettype none

module tb_ex_top
  import ex_pkg::*;
();

  localparam int N_PER_TEST      = 60;
  localparam int N_TESTS         = 5;
  localparam int WATCHDOG_CYCLES = N_PER_TEST * N_TESTS * 20 + 200;
  localparam int SHAMT_W         = $clog2(`EX_XLEN);

  // Request kinds
  localparam int K_ALU    = 0;
  localparam int K_MUL    = 1;
  localparam int K_BRANCH = 2;
  localparam int K_MIXED  = 3;
  localparam int K_LOAD   = 4;

  logic                 clk;
  logic                 rst_n;
  ex_req_t              req_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  logic                 lsu_ready_i;
  logic                 wb_ready_i;
  ex_fwd_t              fwd_o;
  logic                 branch_decision_o;
  logic [`EX_XLEN-1:0]  jump_target_o;
  ex_wb_t               wb_o;
  logic                 mult_multicycle_o;
  logic                 ex_ready_o;
  logic                 ex_valid_o;

  ex_req_t  in_ex[$];        // Accepted, not yet committed
  ex_wb_t   wb_expect;
  logic     wb_pending;      // wb_o due next cycle
  logic     multi_seen;      // High multiply started in EX
  int       errors;
  int       accepts;
  int       commits;
  int       conflicts;
  int       branch_stalled;  // Branches done with LSU or WB busy

  ex_top ex_top_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic compare_flag(alu_op_e op, logic [`EX_XLEN-1:0] a,
                                        logic [`EX_XLEN-1:0] b);
    case (op)
      EQ:        return a == b;
      NE:        return a != b;
      SLT, LT:   return $signed(a) < $signed(b);
      GE:        return $signed(a) >= $signed(b);
      SLTU, LTU: return a < b;
      GEU:       return a >= b;
      default:   return 1'b0;  // Arithmetic ops give no flag
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] expected_wdata(ex_req_t r);
    logic signed [2*`EX_XLEN-1:0]  sprod;
    logic [2*`EX_XLEN-1:0]         uprod;
    logic [`EX_XLEN-1:0]           a;
    logic [`EX_XLEN-1:0]           b;
    a     = r.operand_a;
    b     = r.operand_b;
    sprod = $signed({{`EX_XLEN{a[`EX_XLEN-1]}}, a}) * $signed({{`EX_XLEN{b[`EX_XLEN-1]}}, b});
    uprod = {{`EX_XLEN{1'b0}}, a} * {{`EX_XLEN{1'b0}}, b};
    if (r.mult_en)
    begin
      case (r.mult_op)
        MUL:     return uprod[`EX_XLEN-1:0];
        MULH:    return sprod[2*`EX_XLEN-1:`EX_XLEN];
        MULHU:   return uprod[2*`EX_XLEN-1:`EX_XLEN];
        default: return uprod[`EX_XLEN-1:0] + r.operand_c;  // MAC
      endcase
    end
    if (r.csr_access)
      return r.csr_rdata;
    case (r.alu_op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[SHAMT_W-1:0];
      SRL:     return a >> b[SHAMT_W-1:0];
      SRA:     return $signed(a) >>> b[SHAMT_W-1:0];
      default: return {{(`EX_XLEN-1){1'b0}}, compare_flag(r.alu_op, a, b)};
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Never alu_we and lsu_we together and branches write nothing
  function automatic ex_req_t make_request(int kind, int idx);
    ex_req_t r;
    int      pick;
    r           = '0;
    r.alu_op    = alu_op_e'(4'($urandom_range(15)));
    r.mult_op   = mult_op_e'(2'($urandom_range(3)));
    r.operand_a = $urandom();
    r.operand_b = ($urandom_range(3) == 0) ? r.operand_a : $urandom();  // Hits EQ and GE
    r.operand_c = $urandom();
    r.alu_waddr = 5'($urandom_range(31));
    r.lsu_waddr = 5'($urandom_range(31));
    r.csr_rdata = $urandom();
    pick        = kind;
    if (kind == K_MIXED)
      pick = $urandom_range(3);
    if (pick == K_MIXED)
      pick = K_LOAD;
    if (kind == K_LOAD)
      pick = (idx % 2 == 0) ? K_LOAD : K_ALU;  // Load then ALU write
    case (pick)
      K_ALU:
      begin
        r.alu_we     = 1'b1;
        r.csr_access = ($urandom_range(3) == 0);
      end
      K_MUL:
      begin
        r.alu_we  = 1'b1;
        r.mult_en = 1'b1;
      end
      K_BRANCH:
      begin
        r.branch = 1'b1;
        r.alu_op = alu_op_e'(4'($urandom_range(15, 10)));  // EQ to GEU
      end
      default: r.lsu_we = 1'b1;
    endcase
    return r;
  endfunction

  task automatic report_error(string msg);
    errors++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  // Holds each request until accepted while ready levels change every cycle
  task automatic drive_requests(int kind, int count, int stall_pct);
    int   sent;
    logic took;
    sent = 0;
    @(posedge clk);
    req_i       <= make_request(kind, 0);
    req_valid_i <= 1'b1;
    while (sent < count)
    begin
      lsu_ready_i <= ($urandom_range(99) >= stall_pct);
      wb_ready_i  <= ($urandom_range(99) >= stall_pct);
      @(negedge clk);
      took = req_ready_o;
      @(posedge clk);
      if (took)
      begin
        sent++;
        if (sent < count)
          req_i <= make_request(kind, sent);
        else
          req_valid_i <= 1'b0;
      end
    end
  endtask

  task automatic wait_drain();
    @(posedge clk);
    lsu_ready_i <= 1'b1;
    wb_ready_i  <= 1'b1;
    while (in_ex.size() != 0 || wb_pending)
      @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // Checker
  //////////////////////////////////////////////////

  task automatic check_commit(ex_req_t r);
    logic [`EX_XLEN-1:0] want;
    logic                high_op;
    logic                taken;
    logic                valid_want;
    want       = expected_wdata(r);
    high_op    = r.mult_en && (r.mult_op == MULH || r.mult_op == MULHU);
    taken      = r.branch && compare_flag(r.alu_op, r.operand_a, r.operand_b);
    valid_want = lsu_ready_i && wb_ready_i;  // Multiplier is ready at every commit
    commits++;
    if (fwd_o.we !== r.alu_we)
      report_error($sformatf("fwd_o.we %0b, expected %0b", fwd_o.we, r.alu_we));
    if (r.alu_we && (fwd_o.waddr !== r.alu_waddr || fwd_o.wdata !== want))
      report_error($sformatf("fwd_o x%0d = %h, expected x%0d = %h",
                             fwd_o.waddr, fwd_o.wdata, r.alu_waddr, want));
    if (branch_decision_o !== taken)
      report_error($sformatf("branch_decision_o %0b, expected %0b", branch_decision_o, taken));
    if (r.branch && jump_target_o !== r.operand_c)
      report_error($sformatf("jump_target_o %h, expected %h", jump_target_o, r.operand_c));
    if (high_op != multi_seen || mult_multicycle_o)
      report_error($sformatf("mult_multicycle_o history %0b, expected %0b", multi_seen, high_op));
    if (ex_valid_o !== valid_want)
      report_error($sformatf("ex_valid_o %0b, expected %0b", ex_valid_o, valid_want));
    if (r.branch && !ex_valid_o)
      branch_stalled++;
    multi_seen = 1'b0;
    // Other commits need ex_valid so WB loads the load flag
    if (!r.branch)
    begin
      wb_pending      = 1'b1;
      wb_expect.we    = r.lsu_we;
      wb_expect.waddr = r.lsu_waddr;
    end
  endtask

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (wb_pending)
      begin
        if (wb_o.we !== wb_expect.we || (wb_expect.we && wb_o.waddr !== wb_expect.waddr))
          report_error($sformatf("wb_o we %0b x%0d, expected we %0b x%0d",
                                 wb_o.we, wb_o.waddr, wb_expect.we, wb_expect.waddr));
        wb_pending = 1'b0;
      end
      if (fwd_o.we && wb_o.we)
      begin
        conflicts++;  // Both register file ports wanted
        if (ex_ready_o)
          report_error("ex_ready_o high during a write port conflict");
      end
      if (in_ex.size() > 0 && ex_ready_o)
        check_commit(in_ex.pop_front());
      else if (mult_multicycle_o)
        multi_seen = 1'b1;
      if (req_valid_i && req_ready_o)
      begin
        in_ex.push_back(req_i);  // Enters EX on the next edge
        accepts++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  task automatic run_test(int num, string name, int kind, int stall_pct);
    int err0;
    int acc0;
    int com0;
    int con0;
    int br0;
    err0 = errors;
    acc0 = accepts;
    com0 = commits;
    con0 = conflicts;
    br0  = branch_stalled;
    drive_requests(kind, N_PER_TEST, stall_pct);
    wait_drain();
    if (accepts - acc0 != N_PER_TEST || commits - com0 != accepts - acc0)
      report_error($sformatf("%0d accepted and %0d committed for %0d requests",
                             accepts - acc0, commits - com0, N_PER_TEST));
    if (kind == K_LOAD && conflicts - con0 != N_PER_TEST / 2)
      report_error($sformatf("%0d conflict stalls, expected %0d",
                             conflicts - con0, N_PER_TEST / 2));
    if (kind == K_BRANCH && branch_stalled == br0)
      report_error("no branch committed while LSU or WB was busy");
    $display("Test %0d %s: accepted %0d, committed %0d, conflict stalls %0d, errors %0d",
             num, name, accepts - acc0, commits - com0, conflicts - con0, errors - err0);
  endtask

  initial
  begin
    void'($urandom(77535));
    errors         = 0;
    accepts        = 0;
    commits        = 0;
    conflicts      = 0;
    branch_stalled = 0;
    wb_pending     = 1'b0;
    multi_seen     = 1'b0;
    wb_expect      = '0;
    rst_n          = 1'b0;
    req_i          = '0;
    req_valid_i    = 1'b0;
    lsu_ready_i    = 1'b1;
    wb_ready_i     = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (req_ready_o !== 1'b1 || fwd_o.we !== 1'b0 || wb_o.we !== 1'b0 ||
        mult_multicycle_o !== 1'b0)
      report_error("outputs not idle after reset");
    run_test(1, "alu_csr", K_ALU, 0);
    run_test(2, "multiply", K_MUL, 0);
    run_test(3, "branch", K_BRANCH, 60);
    run_test(4, "backpressure", K_MIXED, 35);
    run_test(5, "load_wb", K_LOAD, 0);
    $display("Summary: %0d tests, %0d accepted, %0d committed, %0d errors",
             N_TESTS, accepts, commits, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Stuck pipeline guard
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog: run passed %0d cycles without finishing", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_stage.sv
ex_issue.sv
ex_top.sv
ex_top_sva.sv
tb_ex_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_ex_top -f project.f -Mdir obj_dir

# Simulator status is not trusted, the log decides
./obj_dir/Vtb_ex_top | tee sim.log

grep -q "Done: no errors" sim.log
echo "Simulation passed"
